// File: filelist.f
+incdir+hw
hw/reflet_pkg.sv
hw/reflet_hardware_info.sv
hw/reflet_exti.sv
hw/reflet_gpio.sv
hw/reflet_timer.sv
hw/reflet_peripheral.sv
testbench/tb_reflet_peripheral.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_reflet_peripheral
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/tb_reflet_peripheral.sv
`timescale 1ns/1ps
`default_nettype none

module tb_reflet_peripheral;

    localparam integer CLK_HALF = 4;
    localparam integer SEED = 50691;

    typedef enum logic [2:0] {
        WRITE,
        READ,
        READ_MAX,
        WRITE_OFF,
        READ_OFF,
        SET_GPI,
        WAIT_CYCLES
    } step_kind_t;

    // lines holds the expected ext_int after the step
    typedef struct packed {
        step_kind_t  kind;
        logic [15:0] at;
        logic [15:0] value;
        logic [15:0] expected;
        logic [3:0]  lines;
    } step_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        enable;
    logic        write_en;
    logic [15:0] addr;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic [3:0]  ext_int;
    logic [15:0] gpi;
    logic [15:0] gpo;

    step_t steps[$];
    int    cycle_count = 0;
    int    cycle_limit = 1000000;

    reflet_peripheral i_reflet_peripheral (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .write_en (write_en),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .ext_int  (ext_int),
        .gpi      (gpi),
        .gpo      (gpo)
    );

    always #CLK_HALF clk = ~clk;

    task automatic stop_run;
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // watchdog against a hung run
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            stop_run();
        end
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        assert (got === expected)
        else
        begin
            $display("[ERROR] %s: got %h, expected %h", name, got, expected);
            stop_run();
        end
    endtask

    task automatic add_step(input step_kind_t kind, input logic [15:0] at,
                            input logic [15:0] value, input logic [15:0] expected,
                            input logic [3:0] lines);
        step_t s;
        s.kind = kind;
        s.at = at;
        s.value = value;
        s.expected = expected;
        s.lines = lines;
        steps.push_back(s);
    endtask

    function automatic int step_cycles(input step_t s);
        if (s.kind == WAIT_CYCLES)
            return int'(s.value);
        return 1;
    endfunction

    task automatic build_table;
        logic [15:0] gpo_val;
        logic [15:0] gpi_cur;
        logic [15:0] bit_m;
        logic [15:0] bit_o;
        int          masked_bit;
        // hardware info writes must not stick
        add_step(READ, 16'hFF00, 16'h0, 16'h0010, 4'h0);
        add_step(READ, 16'hFF01, 16'h0, 16'h0007, 4'h0);
        add_step(READ, 16'hFF02, 16'h0, 16'h007D, 4'h0);
        add_step(READ, 16'hFF03, 16'h0, 16'h0012, 4'h0);
        add_step(WRITE, 16'hFF00, 16'h00AA, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF03, 16'h0055, 16'h0, 4'h0);
        add_step(READ, 16'hFF00, 16'h0, 16'h0010, 4'h0);
        add_step(READ, 16'hFF03, 16'h0, 16'h0012, 4'h0);
        // gpo write with junk in the upper byte then gpi readback
        gpo_val = 16'($urandom);
        add_step(WRITE, 16'hFF09, gpo_val, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF0A, {gpo_val[7:0], gpo_val[15:8]}, 16'h0, 4'h0);
        add_step(READ, 16'hFF09, 16'h0, {8'h00, gpo_val[7:0]}, 4'h0);
        add_step(READ, 16'hFF0A, 16'h0, {8'h00, gpo_val[15:8]}, 4'h0);
        repeat (2)
        begin
            gpi_cur = 16'($urandom);
            add_step(SET_GPI, 16'h0, gpi_cur, 16'h0, 4'h0);
            add_step(WAIT_CYCLES, 16'h0, 16'd2, 16'h0, 4'h0);
            add_step(READ, 16'hFF07, 16'h0, {8'h00, gpi_cur[7:0]}, 4'h0);
            add_step(READ, 16'hFF08, 16'h0, {8'h00, gpi_cur[15:8]}, 4'h0);
        end
        // gpio change interrupt on line 2 and timer on line 1
        masked_bit = int'($urandom % 16);
        bit_m = 16'(1) << masked_bit;
        bit_o = 16'(1) << ((masked_bit + 5) % 16);
        add_step(WRITE, 16'hFF0B, {8'h00, bit_m[7:0]}, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF0C, {8'h00, bit_m[15:8]}, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF06, 16'h0006, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF04, 16'h0001, 16'h0, 4'h0);
        gpi_cur = gpi_cur ^ bit_o;
        add_step(SET_GPI, 16'h0, gpi_cur, 16'h0, 4'h0);
        add_step(WAIT_CYCLES, 16'h0, 16'd4, 16'h0, 4'h0);
        add_step(READ, 16'hFF0D, 16'h0, 16'h0, 4'h0);
        add_step(READ, 16'hFF0E, 16'h0, 16'h0, 4'h0);
        add_step(READ, 16'hFF05, 16'h0, 16'h0, 4'h0);
        gpi_cur = gpi_cur ^ bit_m;
        // sync after 2 edges then flag on the 3rd and pending on the 4th
        add_step(SET_GPI, 16'h0, gpi_cur, 16'h0, 4'h0);
        add_step(WAIT_CYCLES, 16'h0, 16'd2, 16'h0, 4'h0);
        add_step(WAIT_CYCLES, 16'h0, 16'd1, 16'h0, 4'b0100);
        add_step(READ, 16'hFF0D, 16'h0, {8'h00, bit_m[7:0]}, 4'b0100);
        add_step(READ, 16'hFF0E, 16'h0, {8'h00, bit_m[15:8]}, 4'b0100);
        add_step(READ, 16'hFF05, 16'h0, 16'h0001, 4'b0100);
        add_step(WRITE, 16'hFF05, 16'h0001, 16'h0, 4'h0);
        add_step(READ, 16'hFF05, 16'h0, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF0D, 16'h00FF, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF0E, 16'h00FF, 16'h0, 4'h0);
        add_step(READ, 16'hFF0D, 16'h0, 16'h0, 4'h0);
        add_step(READ, 16'hFF0E, 16'h0, 16'h0, 4'h0);
        // first timer match after (4+1)*(3+1) = 20 cycles
        add_step(WRITE, 16'hFF0F, 16'h0003, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF10, 16'h0004, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF04, 16'h0003, 16'h0, 4'h0);
        add_step(READ, 16'hFF0F, 16'h0, 16'h0003, 4'h0);
        add_step(READ, 16'hFF10, 16'h0, 16'h0004, 4'h0);
        add_step(READ, 16'hFF11, 16'h0, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF11, 16'h0001, 16'h0, 4'h0);
        add_step(WAIT_CYCLES, 16'h0, 16'd19, 16'h0, 4'h0);
        add_step(WAIT_CYCLES, 16'h0, 16'd3, 16'h0, 4'b0010);
        add_step(READ, 16'hFF05, 16'h0, 16'h0002, 4'b0010);
        add_step(READ_MAX, 16'hFF11, 16'h0, 16'h0004, 4'b0010);
        add_step(WAIT_CYCLES, 16'h0, 16'd3, 16'h0, 4'b0010);
        add_step(READ_MAX, 16'hFF11, 16'h0, 16'h0004, 4'b0010);
        add_step(WRITE, 16'hFF11, 16'h0000, 16'h0, 4'b0010);
        add_step(READ, 16'hFF11, 16'h0, 16'h0, 4'b0010);
        add_step(WRITE, 16'hFF05, 16'h0002, 16'h0, 4'h0);
        add_step(READ, 16'hFF05, 16'h0, 16'h0, 4'h0);
        // bus disabled or address outside the window
        add_step(READ_OFF, 16'hFF00, 16'h0, 16'h0, 4'h0);
        add_step(READ_OFF, 16'hFF09, 16'h0, 16'h0, 4'h0);
        add_step(WRITE_OFF, 16'hFF09, ~gpo_val, 16'h0, 4'h0);
        add_step(WRITE_OFF, 16'hFF0A, ~{gpo_val[7:0], gpo_val[15:8]}, 16'h0, 4'h0);
        add_step(READ, 16'hFEFF, 16'h0, 16'h0, 4'h0);
        add_step(READ, 16'hFF12, 16'h0, 16'h0, 4'h0);
        add_step(WRITE, 16'hFEFF, ~gpo_val, 16'h0, 4'h0);
        add_step(WRITE, 16'hFF12, ~gpo_val, 16'h0, 4'h0);
        add_step(READ, 16'hFF09, 16'h0, {8'h00, gpo_val[7:0]}, 4'h0);
        add_step(READ, 16'hFF0A, 16'h0, {8'h00, gpo_val[15:8]}, 4'h0);
    endtask

    task automatic apply_step(input step_t s);
        @(negedge clk);
        enable = 1'b0;
        write_en = 1'b0;
        addr = s.at;
        data_in = s.value;
        case (s.kind)
            WRITE:
            begin
                enable = 1'b1;
                write_en = 1'b1;
            end
            READ, READ_MAX: enable = 1'b1;
            WRITE_OFF: write_en = 1'b1;
            SET_GPI: gpi = s.value;
            default: ;
        endcase
        // reads are combinational so sample mid low phase
        #2;
        if (s.kind == READ || s.kind == READ_OFF)
            check_value("data_out", data_out, s.expected);
        if (s.kind == READ && s.at == 16'hFF09)
            check_value("gpo[7:0]", {8'h00, gpo[7:0]}, s.expected);
        if (s.kind == READ && s.at == 16'hFF0A)
            check_value("gpo[15:8]", {8'h00, gpo[15:8]}, s.expected);
        if (s.kind == READ_MAX)
        begin
            assert (data_out <= s.expected)
            else
            begin
                $display("[ERROR] data_out: got %h, above the limit %h", data_out, s.expected);
                stop_run();
            end
        end
        if (s.kind == WAIT_CYCLES)
            repeat (s.value) @(posedge clk);
        else
            @(posedge clk);
        #1;
        check_value("ext_int", {12'h000, ext_int}, {12'h000, s.lines});
    endtask

    initial
    begin
        int total;
        reset = 1'b1;
        enable = 1'b0;
        write_en = 1'b0;
        addr = 16'h0;
        data_in = 16'h0;
        gpi = 16'h0;
        void'($urandom(SEED));
        build_table();
        total = 0;
        foreach (steps[i])
            total = total + step_cycles(steps[i]);
        cycle_limit = 3 + total + 64;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (steps[i])
            apply_step(steps[i]);
        @(negedge clk);
        enable = 1'b0;
        write_en = 1'b0;
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/reflet_peripheral.sv
`timescale 1ns/1ps
`default_nettype none

`include "reflet_config.svh"

module reflet_peripheral
    import reflet_pkg::*;
#(
    parameter integer ENABLE_EXTI = `REFLET_ENABLE_EXTI,
    parameter integer ENABLE_GPIO = `REFLET_ENABLE_GPIO,
    parameter integer ENABLE_TIMER = `REFLET_ENABLE_TIMER
)(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        enable,
    input  wire logic        write_en,
    input  wire addr_t       addr,
    input  wire word_t       data_in,
    output word_t            data_out,
    output int_lines_t       ext_int,
    input  wire logic [15:0] gpi,
    output logic [15:0]      gpo
);

    addr_t   addr_diff;
    logic    sel;
    offset_t offset;
    reg_t    wr_byte;
    reg_t    hwi_rd;
    reg_t    exti_rd;
    reg_t    gpio_rd;
    reg_t    timer_rd;
    logic    gpio_int;
    logic    timer_int;

    // window decode, wraps below the base
    assign addr_diff = addr - addr_t'(`REFLET_BASE_ADDR);
    assign sel = enable && (addr_diff < addr_t'(TOTAL_REGS));
    assign offset = addr_diff[4:0];
    assign wr_byte = data_in[7:0];

    // unselected units return zero
    assign data_out = {{(`REFLET_WORDSIZE - 8){1'b0}}, hwi_rd | exti_rd | gpio_rd | timer_rd};

    reflet_hardware_info #(
        .ENABLE_EXTI  (ENABLE_EXTI),
        .ENABLE_GPIO  (ENABLE_GPIO),
        .ENABLE_TIMER (ENABLE_TIMER)
    ) i_hwi (
        .offset  (offset),
        .sel     (sel),
        .rd_data (hwi_rd)
    );

    if (ENABLE_EXTI != 0)
    begin : g_exti
        reflet_exti i_exti (
            .clk       (clk),
            .reset     (reset),
            .sel       (sel),
            .write_en  (write_en),
            .offset    (offset),
            .data_in   (wr_byte),
            .rd_data   (exti_rd),
            .gpio_int  (gpio_int),
            .timer_int (timer_int),
            .ext_int   (ext_int)
        );
    end
    else
    begin : g_no_exti
        assign exti_rd = '0;
        assign ext_int = '0;
    end

    if (ENABLE_GPIO != 0)
    begin : g_gpio
        reflet_gpio i_gpio (
            .clk      (clk),
            .reset    (reset),
            .sel      (sel),
            .write_en (write_en),
            .offset   (offset),
            .data_in  (wr_byte),
            .rd_data  (gpio_rd),
            .gpi      (gpi),
            .gpo      (gpo),
            .gpio_int (gpio_int)
        );
    end
    else
    begin : g_no_gpio
        assign gpio_rd = '0;
        assign gpo = '0;
        assign gpio_int = 1'b0;
    end

    if (ENABLE_TIMER != 0)
    begin : g_timer
        reflet_timer i_timer (
            .clk       (clk),
            .reset     (reset),
            .sel       (sel),
            .write_en  (write_en),
            .offset    (offset),
            .data_in   (wr_byte),
            .rd_data   (timer_rd),
            .timer_int (timer_int)
        );
    end
    else
    begin : g_no_timer
        assign timer_rd = '0;
        assign timer_int = 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/reflet_timer.sv
`timescale 1ns/1ps
`default_nettype none

module reflet_timer
    import reflet_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    sel,
    input  wire logic    write_en,
    input  wire offset_t offset,
    input  wire reg_t    data_in,
    output reg_t         rd_data,
    output logic         timer_int
);

    offset_t      idx;
    logic         hit;
    logic         wr;
    timer_state_t state;
    reg_t         prescaler;
    reg_t         compare;
    reg_t         pre_cnt;
    reg_t         counter;

    assign idx = offset - offset_t'(TIMER_OFF);
    assign hit = sel && (offset >= offset_t'(TIMER_OFF))
                     && (offset < offset_t'(TIMER_OFF + TIMER_SIZE));
    assign wr = write_en && hit;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= IDLE;
            prescaler <= '0;
            compare   <= '0;
            pre_cnt   <= '0;
            counter   <= '0;
            timer_int <= 1'b0;
        end
        else
        begin
            timer_int <= 1'b0;
            if (wr && idx == 5'd0)
                prescaler <= data_in;
            if (wr && idx == 5'd1)
                compare <= data_in;
            if (wr && idx == 5'd2 && !data_in[0])
            begin
                // stop and clear both counters
                state   <= IDLE;
                pre_cnt <= '0;
                counter <= '0;
            end
            else if (wr && idx == 5'd2 && state == IDLE)
                state <= RUN;
            else if (state == RUN)
            begin
                if (pre_cnt == prescaler)
                begin
                    pre_cnt <= '0;
                    if (counter == compare)
                    begin
                        counter   <= '0;
                        timer_int <= 1'b1;
                    end
                    else
                        counter <= counter + 8'd1;
                end
                else
                    pre_cnt <= pre_cnt + 8'd1;
            end
        end
    end

    always_comb
    begin
        rd_data = '0;
        if (hit)
        begin
            case (idx)
                5'd0: rd_data = prescaler;
                5'd1: rd_data = compare;
                5'd2: rd_data = counter;
                default: rd_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/reflet_gpio.sv
`timescale 1ns/1ps
`default_nettype none

module reflet_gpio
    import reflet_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        sel,
    input  wire logic        write_en,
    input  wire offset_t     offset,
    input  wire reg_t        data_in,
    output reg_t             rd_data,
    input  wire logic [15:0] gpi,
    output logic [15:0]      gpo,
    output logic             gpio_int
);

    offset_t     idx;
    logic        hit;
    logic        wr;
    logic [15:0] gpi_meta;
    logic [15:0] gpi_sync;
    logic [15:0] gpi_prev;
    logic [15:0] chg_mask;
    logic [15:0] chg_flags;
    logic [15:0] changed;
    logic [15:0] flag_clr;

    assign idx = offset - offset_t'(GPIO_OFF);
    assign hit = sel && (offset >= offset_t'(GPIO_OFF))
                     && (offset < offset_t'(GPIO_OFF + GPIO_SIZE));
    assign wr = write_en && hit;

    // only masked bits count as a change
    assign changed = (gpi_sync ^ gpi_prev) & chg_mask;

    assign flag_clr = {(wr && idx == 5'd7) ? data_in : 8'h00,
                       (wr && idx == 5'd6) ? data_in : 8'h00};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            gpi_meta  <= '0;
            gpi_sync  <= '0;
            gpi_prev  <= '0;
            gpo       <= '0;
            chg_mask  <= '0;
            chg_flags <= '0;
            gpio_int  <= 1'b0;
        end
        else
        begin
            // two stage synchronizer
            gpi_meta <= gpi;
            gpi_sync <= gpi_meta;
            gpi_prev <= gpi_sync;
            if (wr && idx == 5'd2)
                gpo[7:0] <= data_in;
            if (wr && idx == 5'd3)
                gpo[15:8] <= data_in;
            if (wr && idx == 5'd4)
                chg_mask[7:0] <= data_in;
            if (wr && idx == 5'd5)
                chg_mask[15:8] <= data_in;
            chg_flags <= (chg_flags & ~flag_clr) | changed;
            gpio_int  <= |changed;
        end
    end

    always_comb
    begin
        rd_data = '0;
        if (hit)
        begin
            case (idx)
                5'd0: rd_data = gpi_sync[7:0];
                5'd1: rd_data = gpi_sync[15:8];
                5'd2: rd_data = gpo[7:0];
                5'd3: rd_data = gpo[15:8];
                5'd4: rd_data = chg_mask[7:0];
                5'd5: rd_data = chg_mask[15:8];
                5'd6: rd_data = chg_flags[7:0];
                5'd7: rd_data = chg_flags[15:8];
                default: rd_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/reflet_exti.sv
`timescale 1ns/1ps
`default_nettype none

module reflet_exti
    import reflet_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    sel,
    input  wire logic    write_en,
    input  wire offset_t offset,
    input  wire reg_t    data_in,
    output reg_t         rd_data,
    input  wire logic    gpio_int,
    input  wire logic    timer_int,
    output int_lines_t   ext_int
);

    offset_t    idx;
    logic       hit;
    logic [1:0] src_mask;
    logic [1:0] pending;
    logic [3:0] routing;
    logic [1:0] src_pulse;
    logic [1:0] pend_clr;

    assign idx = offset - offset_t'(EXTI_OFF);
    assign hit = sel && (offset >= offset_t'(EXTI_OFF))
                     && (offset < offset_t'(EXTI_OFF + EXTI_SIZE));

    // bit0 gpio, bit1 timer
    assign src_pulse = {timer_int, gpio_int};
    assign pend_clr = (write_en && hit && idx == 5'd1) ? data_in[1:0] : 2'b00;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            src_mask <= '0;
            pending  <= '0;
            routing  <= '0;
        end
        else
        begin
            if (write_en && hit && idx == 5'd0)
                src_mask <= data_in[1:0];
            if (write_en && hit && idx == 5'd2)
                routing <= data_in[3:0];
            // a new pulse beats a clear in the same cycle
            pending <= (pending & ~pend_clr) | src_pulse;
        end
    end

    // route enabled flags onto the processor lines
    always_comb
    begin
        ext_int = '0;
        if (pending[0] && src_mask[0])
            ext_int[routing[1:0]] = 1'b1;
        if (pending[1] && src_mask[1])
            ext_int[routing[3:2]] = 1'b1;
    end

    always_comb
    begin
        rd_data = '0;
        if (hit)
        begin
            case (idx)
                5'd0: rd_data = reg_t'(src_mask);
                5'd1: rd_data = reg_t'(pending);
                5'd2: rd_data = reg_t'(routing);
                default: rd_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/reflet_hardware_info.sv
`timescale 1ns/1ps
`default_nettype none

`include "reflet_config.svh"

module reflet_hardware_info
    import reflet_pkg::*;
#(
    parameter integer ENABLE_EXTI = 1,
    parameter integer ENABLE_GPIO = 1,
    parameter integer ENABLE_TIMER = 1
)(
    input  wire offset_t offset,
    input  wire logic    sel,
    output reg_t         rd_data
);

    localparam integer CLK_MHZ = `REFLET_CLK_FREQ / 1000000;

    offset_t idx;
    logic    hit;

    assign idx = offset - offset_t'(HWI_OFF);
    assign hit = sel && (offset >= offset_t'(HWI_OFF))
                     && (offset < offset_t'(HWI_OFF + HWI_SIZE));

    // read-only description of this build
    always_comb
    begin
        rd_data = '0;
        if (hit)
        begin
            case (idx)
                5'd0: rd_data = reg_t'(`REFLET_WORDSIZE);
                5'd1: rd_data = {5'b0, ENABLE_TIMER != 0, ENABLE_GPIO != 0, ENABLE_EXTI != 0};
                5'd2: rd_data = reg_t'(CLK_MHZ);
                5'd3: rd_data = reg_t'(TOTAL_REGS);
                default: rd_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/reflet_pkg.sv
`default_nettype none

`include "reflet_config.svh"

package reflet_pkg;

    // bus level vectors
    typedef logic [`REFLET_WORDSIZE-1:0] word_t;
    typedef logic [`REFLET_ADDR_SIZE-1:0] addr_t;

    // one peripheral register and an offset inside the window
    typedef logic [7:0] reg_t;
    typedef logic [4:0] offset_t;

    // processor interrupt lines
    typedef logic [3:0] int_lines_t;

    // register map of the window
    localparam integer HWI_OFF = 0;
    localparam integer HWI_SIZE = 4;
    localparam integer EXTI_OFF = HWI_OFF + HWI_SIZE;
    localparam integer EXTI_SIZE = 3;
    localparam integer GPIO_OFF = EXTI_OFF + EXTI_SIZE;
    localparam integer GPIO_SIZE = 8;
    localparam integer TIMER_OFF = GPIO_OFF + GPIO_SIZE;
    localparam integer TIMER_SIZE = 3;
    localparam integer TOTAL_REGS = TIMER_OFF + TIMER_SIZE;

    // timer FSM
    typedef enum logic {
        IDLE,
        RUN
    } timer_state_t;

endpackage

`default_nettype wire

// File: hw/reflet_config.svh
`ifndef REFLET_CONFIG_SVH
`define REFLET_CONFIG_SVH

// processor bus widths
`define REFLET_WORDSIZE 16
`define REFLET_ADDR_SIZE 16

// first address of the peripheral window
`define REFLET_BASE_ADDR 16'hFF00

// system clock in Hz
`define REFLET_CLK_FREQ 125000000

// default unit enables of the top level
`define REFLET_ENABLE_EXTI 1
`define REFLET_ENABLE_GPIO 1
`define REFLET_ENABLE_TIMER 1

`endif
